//--- files.f
+incdir+include
hw/mem_pkg.sv
hw/lane_steering.sv
hw/byte_lane_bank.sv
hw/load_extender.sv
hw/data_memory_unit.sv
testbench/tb_data_memory_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the data memory testbench with Verilator and runs it, output in sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_data_memory_unit \
  -f files.f -o tb_sim > sim.log 2>&1 \
  && ./obj_dir/tb_sim >> sim.log 2>&1 \
  || { cat sim.log; echo "Build or simulation did not complete"; exit 1; }

cat sim.log

# Result decided by the fail message in the log
grep -qx "Finished with errors" sim.log \
  && { echo "Simulation FAILED"; exit 1; } \
  || { echo "Simulation PASSED"; exit 0; }

//--- testbench/tb_data_memory_unit.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module tb_data_memory_unit import mem_pkg::*; ();

  localparam int BYTES = `MEM_WORDS * `MEM_LANES;

  logic                    i_clock;
  logic                    i_reset;
  logic                    i_enable;
  logic                    i_mem_write;
  logic                    i_mem_read;
  mem_size_t               i_size;
  logic                    i_unsigned;
  logic [`MEM_ADDR_W-1:0]  i_address;
  word_t                   i_write_data;
  logic                    i_debug_read_enable;
  logic [`MEM_ADDR_W-3:0]  i_debug_word_address;
  word_t                   o_read_data;
  logic                    o_read_valid;
  logic                    o_misaligned;
  word_t                   o_debug_word;

  lane_t       model_mem [BYTES];  // Byte-array mirror of the banks
  word_t       exp_q [$];          // Expected load results in issue order
  string       name_q [$];         // Test name per expected load
  logic [31:0] rng;
  logic        stage_on;           // Enable as the DUT will sample it
  int          errors;
  int          timeouts;

  data_memory_unit UUT (
    .i_clock              (i_clock),
    .i_reset              (i_reset),
    .i_enable             (i_enable),
    .i_mem_write          (i_mem_write),
    .i_mem_read           (i_mem_read),
    .i_size               (i_size),
    .i_unsigned           (i_unsigned),
    .i_address            (i_address),
    .i_write_data         (i_write_data),
    .i_debug_read_enable  (i_debug_read_enable),
    .i_debug_word_address (i_debug_word_address),
    .o_read_data          (o_read_data),
    .o_read_valid         (o_read_valid),
    .o_misaligned         (o_misaligned),
    .o_debug_word         (o_debug_word)
  );

  // 40 ns clock
  initial begin
    i_clock = 1'b0;
    forever #20 i_clock = ~i_clock;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic aligned_for(input mem_size_t size, input logic [1:0] offset);
    case (size)
      SIZE_BYTE: return 1'b1;
      SIZE_HALF: return offset[0] == 1'b0;   // Even byte
      default:   return offset == 2'b00;     // Word boundary
    endcase
  endfunction

  function automatic word_t model_word(input logic [`MEM_ADDR_W-1:0] addr);
    int base;
    base = int'({addr[`MEM_ADDR_W-1:2], 2'b00});
    return {model_mem[base+3], model_mem[base+2], model_mem[base+1], model_mem[base]};
  endfunction

  // Expected load value from word, size, offset and unsigned flag
  function automatic word_t ref_load(input word_t w, input mem_size_t size,
                                     input logic [1:0] offset, input logic uns);
    word_t shifted;
    word_t result;
    shifted = w >> (8 * offset);             // Addressed byte to bit 0
    case (size)
      SIZE_BYTE: result = (!uns && shifted[7]) ? (shifted | 32'hffff_ff00)
                                               : (shifted & 32'h0000_00ff);
      SIZE_HALF: result = (!uns && shifted[15]) ? (shifted | 32'hffff_0000)
                                                : (shifted & 32'h0000_ffff);
      default:   result = w;
    endcase
    return result;
  endfunction

  task automatic model_store(input mem_size_t size, input logic [`MEM_ADDR_W-1:0] addr,
                             input word_t data);
    int base;
    int count;
    base  = int'(addr);
    count = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
    for (int k = 0; k < count; k++) begin
      model_mem[base + k] = data[8*k +: 8];  // Right-aligned store data
    end
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected %08h, actual %08h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
      errors++;
    end
  endtask

  // One request cycle driven at the rising edge
  task automatic drive_access(input logic wr, input logic rd, input mem_size_t size,
                              input logic uns, input logic [`MEM_ADDR_W-1:0] addr,
                              input word_t data);
    @(posedge i_clock);
    i_mem_write  <= wr;
    i_mem_read   <= rd;
    i_size       <= size;
    i_unsigned   <= uns;
    i_address    <= addr;
    i_write_data <= data;
  endtask

  task automatic idle_cycle();
    @(posedge i_clock);
    i_mem_write <= 1'b0;
    i_mem_read  <= 1'b0;
  endtask

  task automatic set_enable(input logic en);
    @(posedge i_clock);
    i_enable <= en;
    stage_on = en;
  endtask

  task automatic store_op(input mem_size_t size, input logic [`MEM_ADDR_W-1:0] addr,
                          input word_t data);
    drive_access(1'b1, 1'b0, size, 1'b0, addr, data);
    if (stage_on && aligned_for(size, addr[1:0])) begin
      model_store(size, addr, data);
    end
  endtask

  task automatic load_op(input string name, input mem_size_t size, input logic uns,
                         input logic [`MEM_ADDR_W-1:0] addr);
    drive_access(1'b0, 1'b1, size, uns, addr, '0);
    if (stage_on && aligned_for(size, addr[1:0])) begin
      exp_q.push_back(ref_load(model_word(addr), size, addr[1:0], uns));
      name_q.push_back(name);
    end
  endtask

  // Misaligned request and its one-cycle flag
  task automatic misaligned_op(input string name, input logic wr, input mem_size_t size,
                               input logic [`MEM_ADDR_W-1:0] addr);
    drive_access(wr, ~wr, size, 1'b0, addr, 32'hdead_beef);
    idle_cycle();                            // Edge that samples the request
    @(negedge i_clock);
    check_flag({name, " misaligned"}, 1'b1, o_misaligned);
    check_flag({name, " read valid"}, 1'b0, o_read_valid);
    @(posedge i_clock);                      // Idle cycle sampled
    @(negedge i_clock);
    check_flag({name, " misaligned end"}, 1'b0, o_misaligned);
  endtask

  task automatic wait_loads_done(input string what);
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < 20) begin
      @(posedge i_clock);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout while waiting for %s results, %0d loads got no read valid",
               what, exp_q.size());
      timeouts++;
      exp_q.delete();
      name_q.delete();
    end
  endtask

  task automatic debug_check(input logic [`MEM_ADDR_W-3:0] windex);
    word_t expected;
    expected = model_word({windex, 2'b00});
    @(posedge i_clock);
    i_debug_read_enable  <= 1'b1;
    i_debug_word_address <= windex;
    @(posedge i_clock);                      // Sampled here
    i_debug_read_enable <= 1'b0;
    @(negedge i_clock);
    check_word("debug read", expected, o_debug_word);
    @(posedge i_clock);                      // Enable sampled low
    @(negedge i_clock);
    check_word("debug read disabled", 32'h0, o_debug_word);
  endtask

  // Every read valid pulse against the oldest expected load
  always @(negedge i_clock) begin
    if (!i_reset && o_read_valid) begin
      if (exp_q.size() == 0) begin
        $display("A read valid pulse arrived while no load was outstanding");
        errors++;
      end else begin
        check_word(name_q.pop_front(), exp_q.pop_front(), o_read_data);
      end
    end
  end

  initial begin
    logic [`MEM_ADDR_W-1:0] word_addrs [16];
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_ADDR_W-1:0] base;
    mem_size_t              size;
    word_t                  data;

    rng      = 32'h9a72;
    errors   = 0;
    timeouts = 0;
    stage_on = 1'b1;
    for (int b = 0; b < BYTES; b++) begin
      model_mem[b] = '0;                     // Banks start cleared
    end
    i_reset              = 1'b1;
    i_enable             = 1'b1;
    i_mem_write          = 1'b0;
    i_mem_read           = 1'b0;
    i_size               = SIZE_WORD;
    i_unsigned           = 1'b0;
    i_address            = '0;
    i_write_data         = '0;
    i_debug_read_enable  = 1'b0;
    i_debug_word_address = '0;

    repeat (3) @(posedge i_clock);
    @(negedge i_clock);
    check_word("reset read data", 32'h0, o_read_data);
    check_word("reset debug word", 32'h0, o_debug_word);
    check_flag("reset read valid", 1'b0, o_read_valid);
    check_flag("reset misaligned", 1'b0, o_misaligned);
    @(posedge i_clock);
    i_reset <= 1'b0;                         // Fourth edge still in reset

    // Word stores followed by back-to-back word loads
    for (int idx = 0; idx < 16; idx++) begin
      rng = xorshift(rng);
      word_addrs[idx] = {rng[`MEM_ADDR_W+1:4], 2'b00};
      rng = xorshift(rng);
      store_op(SIZE_WORD, word_addrs[idx], rng);
    end
    for (int idx = 0; idx < 16; idx++) begin
      load_op("word load", SIZE_WORD, 1'b0, word_addrs[idx]);
    end
    idle_cycle();
    wait_loads_done("word load");

    // Byte and halfword stores with a word load after each
    for (int idx = 0; idx < 24; idx++) begin
      rng  = xorshift(rng);
      addr = rng[`MEM_ADDR_W-1:0];
      if (rng[20]) begin
        size    = SIZE_HALF;
        addr[0] = 1'b0;
      end else begin
        size = SIZE_BYTE;
      end
      rng = xorshift(rng);
      store_op(size, addr, rng);
      load_op("partial store", SIZE_WORD, 1'b0, {addr[`MEM_ADDR_W-1:2], 2'b00});
    end
    idle_cycle();
    wait_loads_done("partial store");

    // Sub-word loads at every legal offset with both extensions
    for (int idx = 0; idx < 8; idx++) begin
      rng  = xorshift(rng);
      base = {rng[`MEM_ADDR_W+1:4], 2'b00};
      rng  = xorshift(rng);
      data = (idx == 0) ? 32'h7f01_ff80 : rng;  // Both sign cases in one word
      store_op(SIZE_WORD, base, data);
      for (int off = 0; off < 4; off++) begin
        load_op("byte signed", SIZE_BYTE, 1'b0, {base[`MEM_ADDR_W-1:2], 2'(off)});
        load_op("byte unsigned", SIZE_BYTE, 1'b1, {base[`MEM_ADDR_W-1:2], 2'(off)});
      end
      for (int off = 0; off < 4; off += 2) begin
        load_op("half signed", SIZE_HALF, 1'b0, {base[`MEM_ADDR_W-1:2], 2'(off)});
        load_op("half unsigned", SIZE_HALF, 1'b1, {base[`MEM_ADDR_W-1:2], 2'(off)});
      end
    end
    idle_cycle();
    wait_loads_done("sub-word load");

    // Misaligned accesses leave the word alone
    base = word_addrs[2];
    misaligned_op("word store at +1", 1'b1, SIZE_WORD, {base[`MEM_ADDR_W-1:2], 2'd1});
    misaligned_op("word store at +2", 1'b1, SIZE_WORD, {base[`MEM_ADDR_W-1:2], 2'd2});
    misaligned_op("half store at +1", 1'b1, SIZE_HALF, {base[`MEM_ADDR_W-1:2], 2'd1});
    misaligned_op("half store at +3", 1'b1, SIZE_HALF, {base[`MEM_ADDR_W-1:2], 2'd3});
    misaligned_op("word load at +3", 1'b0, SIZE_WORD, {base[`MEM_ADDR_W-1:2], 2'd3});
    misaligned_op("half load at +1", 1'b0, SIZE_HALF, {base[`MEM_ADDR_W-1:2], 2'd1});
    load_op("after misaligned", SIZE_WORD, 1'b0, base);
    idle_cycle();
    wait_loads_done("after misaligned");

    // Debug port
    for (int idx = 0; idx < 4; idx++) begin
      debug_check(word_addrs[idx][`MEM_ADDR_W-1:2]);
    end

    // Frozen stage ignores stores and loads
    set_enable(1'b0);
    store_op(SIZE_WORD, word_addrs[0], ~model_word(word_addrs[0]));
    store_op(SIZE_BYTE, {word_addrs[1][`MEM_ADDR_W-1:2], 2'd1}, 32'h0000_00a5);
    load_op("disabled load", SIZE_WORD, 1'b0, word_addrs[0]);
    idle_cycle();
    @(negedge i_clock);
    check_flag("disabled load read valid", 1'b0, o_read_valid);
    set_enable(1'b1);
    load_op("after disabled", SIZE_WORD, 1'b0, word_addrs[0]);
    load_op("after disabled", SIZE_WORD, 1'b0, word_addrs[1]);
    idle_cycle();
    wait_loads_done("after disabled");

    repeat (3) @(posedge i_clock);
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- hw/data_memory_unit.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module data_memory_unit import mem_pkg::*; (
  input  logic                    i_clock,
  input  logic                    i_reset,
  input  logic                    i_enable,
  input  logic                    i_mem_write,
  input  logic                    i_mem_read,
  input  mem_size_t               i_size,
  input  logic                    i_unsigned,
  input  logic [`MEM_ADDR_W-1:0]  i_address,
  input  word_t                   i_write_data,
  input  logic                    i_debug_read_enable,
  input  logic [`MEM_ADDR_W-3:0]  i_debug_word_address,
  output word_t                   o_read_data,
  output logic                    o_read_valid,
  output logic                    o_misaligned,
  output word_t                   o_debug_word
);

  lane_t                   lane_data   [`MEM_LANES];
  lane_t                   access_bytes [`MEM_LANES];
  lane_t                   debug_bytes  [`MEM_LANES];
  lane_mask_t              lane_write;
  logic [`MEM_ADDR_W-3:0]  word_index;
  logic                    access_read;

  // Size and offset into lane strobes
  lane_steering u_steering (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_enable      (i_enable),
    .i_mem_write   (i_mem_write),
    .i_mem_read    (i_mem_read),
    .i_size        (i_size),
    .i_address     (i_address),
    .i_write_data  (i_write_data),
    .o_lane_data   (lane_data),
    .o_lane_write  (lane_write),
    .o_word_index  (word_index),
    .o_access_read (access_read),
    .o_misaligned  (o_misaligned)
  );

  // One bank per byte lane
  for (genvar g = 0; g < `MEM_LANES; g++) begin : g_lane
    byte_lane_bank u_bank (
      .i_clock              (i_clock),
      .i_reset              (i_reset),
      .i_enable             (i_enable),
      .i_write              (lane_write[g]),
      .i_word_index         (word_index),
      .i_write_byte         (lane_data[g]),
      .i_access_read        (access_read),
      .i_debug_read_enable  (i_debug_read_enable),
      .i_debug_word_address (i_debug_word_address),
      .o_access_byte        (access_bytes[g]),
      .o_debug_byte         (debug_bytes[g])
    );
  end

  // Debug word from the four lane bytes, lane 0 lowest
  always_comb begin
    for (int lane = 0; lane < `MEM_LANES; lane++) begin
      o_debug_word[8*lane +: 8] = debug_bytes[lane];
    end
  end

  load_extender u_extender (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_access_read (access_read),
    .i_size        (i_size),
    .i_unsigned    (i_unsigned),
    .i_byte_offset (i_address[1:0]),  // Offset within the word
    .i_lane_bytes  (access_bytes),
    .o_read_data   (o_read_data),
    .o_read_valid  (o_read_valid)
  );

endmodule

//--- hw/load_extender.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module load_extender import mem_pkg::*; (
  input  logic        i_clock,
  input  logic        i_reset,
  input  logic        i_access_read,
  input  mem_size_t   i_size,
  input  logic        i_unsigned,
  input  logic [1:0]  i_byte_offset,
  input  lane_t       i_lane_bytes [`MEM_LANES],
  output word_t       o_read_data,
  output logic        o_read_valid
);

  mem_size_t  size_q;
  logic [1:0] offset_q;
  logic       unsigned_q;
  lane_t      sel_byte;
  logic [15:0] sel_half;
  logic       sign_fill;
  word_t      full_word;

  // Load attributes kept until the bank bytes arrive
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      size_q       <= SIZE_BYTE;
      offset_q     <= 2'b00;
      unsigned_q   <= 1'b1;
      o_read_valid <= 1'b0;
    end else begin
      o_read_valid <= i_access_read;  // Bank bytes are valid next cycle
      if (i_access_read) begin
        size_q     <= i_size;
        offset_q   <= i_byte_offset;
        unsigned_q <= i_unsigned;
      end
    end
  end

  // Byte and halfword picked from the registered lanes
  assign sel_byte = i_lane_bytes[offset_q];
  assign sel_half = {i_lane_bytes[{offset_q[1], 1'b1}], i_lane_bytes[{offset_q[1], 1'b0}]};

  always_comb begin
    for (int lane = 0; lane < `MEM_LANES; lane++) begin
      full_word[8*lane +: 8] = i_lane_bytes[lane];
    end
  end

  // Extension of the picked bytes, holds while banks hold
  always_comb begin
    case (size_q)
      SIZE_BYTE: begin
        sign_fill   = ~unsigned_q & sel_byte[7];
        o_read_data = {{24{sign_fill}}, sel_byte};
      end
      SIZE_HALF: begin
        sign_fill   = ~unsigned_q & sel_half[15];
        o_read_data = {{16{sign_fill}}, sel_half};
      end
      default: begin
        sign_fill   = 1'b0;                        // Nothing to extend
        o_read_data = full_word;
      end
    endcase
  end

  // Valid is a single pulse per strobe
  a_valid_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
    (o_read_valid && !i_access_read) |=> !o_read_valid);

endmodule

//--- hw/byte_lane_bank.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module byte_lane_bank import mem_pkg::*; (
  input  logic                    i_clock,
  input  logic                    i_reset,
  input  logic                    i_enable,
  input  logic                    i_write,
  input  logic [`MEM_ADDR_W-3:0]  i_word_index,
  input  lane_t                   i_write_byte,
  input  logic                    i_access_read,
  input  logic                    i_debug_read_enable,
  input  logic [`MEM_ADDR_W-3:0]  i_debug_word_address,
  output lane_t                   o_access_byte,
  output lane_t                   o_debug_byte
);

  lane_t mem [`MEM_WORDS];  // One byte of every word

  // Memory starts cleared
  initial begin
    for (int idx = 0; idx < `MEM_WORDS; idx++) begin
      mem[idx] = '0;
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_write && i_enable) begin
      mem[i_word_index] <= i_write_byte;  // Old byte still read this edge
    end
  end

  // Access and debug read registers
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      o_access_byte <= '0;
      o_debug_byte  <= '0;
    end else if (i_enable) begin
      if (i_access_read) begin
        o_access_byte <= mem[i_word_index];  // Otherwise holds last load
      end
      // Debug port shows zero when not requested
      o_debug_byte <= i_debug_read_enable ? mem[i_debug_word_address] : '0;
    end
  end

  // Indices reaching the array stay in range
  a_index_in_range: assert property (@(posedge i_clock) disable iff (i_reset)
    (i_write || i_access_read) |-> (i_word_index < `MEM_WORDS));

  a_debug_in_range: assert property (@(posedge i_clock) disable iff (i_reset)
    i_debug_read_enable |-> (i_debug_word_address < `MEM_WORDS));

endmodule

//--- hw/lane_steering.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module lane_steering import mem_pkg::*; (
  input  logic                    i_clock,
  input  logic                    i_reset,
  input  logic                    i_enable,
  input  logic                    i_mem_write,
  input  logic                    i_mem_read,
  input  mem_size_t               i_size,
  input  logic [`MEM_ADDR_W-1:0]  i_address,
  input  word_t                   i_write_data,
  output lane_t                   o_lane_data [`MEM_LANES],
  output lane_mask_t              o_lane_write,
  output logic [`MEM_ADDR_W-3:0]  o_word_index,
  output logic                    o_access_read,
  output logic                    o_misaligned
);

  logic [1:0] byte_offset;
  logic       aligned;
  logic       access_ok;
  lane_mask_t size_mask;

  assign byte_offset  = i_address[1:0];
  assign o_word_index = i_address[`MEM_ADDR_W-1:2];  // Same index for every bank

  // Lanes covered by the access and whether the offset fits the size
  always_comb begin
    case (i_size)
      SIZE_BYTE: begin
        size_mask = lane_mask_t'(1) << byte_offset;
        aligned   = 1'b1;
      end
      SIZE_HALF: begin
        size_mask = lane_mask_t'(2'b11) << byte_offset;
        aligned   = ~byte_offset[0];
      end
      default: begin
        size_mask = '1;                            // Whole word
        aligned   = (byte_offset == 2'b00);
      end
    endcase
  end

  // Store data replicated so each lane sees its own byte
  always_comb begin
    for (int lane = 0; lane < `MEM_LANES; lane++) begin
      case (i_size)
        SIZE_BYTE: o_lane_data[lane] = i_write_data[7:0];
        SIZE_HALF: o_lane_data[lane] = lane[0] ? i_write_data[15:8] : i_write_data[7:0];
        default:   o_lane_data[lane] = i_write_data[8*lane +: 8];
      endcase
    end
  end

  assign access_ok     = i_enable & aligned;
  assign o_lane_write  = (i_mem_write & access_ok) ? size_mask : '0;
  assign o_access_read = i_mem_read & access_ok;

  // One-cycle flag for a rejected access
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      o_misaligned <= 1'b0;
    end else begin
      o_misaligned <= i_enable & (i_mem_write | i_mem_read) & ~aligned;
    end
  end

  // A flagged access never reached the banks
  a_no_write_on_misalign: assert property (@(posedge i_clock) disable iff (i_reset)
    o_misaligned |-> $past(o_lane_write) == '0);

endmodule

//--- hw/mem_pkg.sv
`include "mem_defines.svh"

package mem_pkg;

  // Access width of a load or store
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } mem_size_t;

  typedef logic [31:0] word_t;              // Full data word
  typedef logic [7:0]  lane_t;              // One byte lane

  // Bit 0 is the least significant byte
  typedef logic [`MEM_LANES-1:0] lane_mask_t;

endpackage

//--- include/mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// Byte address width, 3 or more
`define MEM_ADDR_W 9

// Words in the memory, one per lane entry
`define MEM_WORDS (1 << (`MEM_ADDR_W - 2))

// Byte lanes per 32-bit word
`define MEM_LANES 4

`endif
